//--- design/audio_pkg.sv
// Widths are fixed for a 12-bit offset-binary microphone and 16-bit I2S; change them together
package audio_pkg;

    // --------------------
    // Sample widths

    localparam int mic_raw_w     = 12;                  // Microphone code width
    localparam int audio_w       = 16;                  // I2S word width
    localparam int audio_shift_c = audio_w - mic_raw_w; // Left shift from mic code to audio

    typedef logic        [mic_raw_w-1:0] mic_raw_t;     // Offset-binary mic code
    typedef logic signed [audio_w-1:0]   audio_t;       // Signed audio sample

    localparam mic_raw_t mic_offset_c = 12'h800;        // Mid-scale of the mic code

    // --------------------
    // Frame geometry

    localparam int mic_bits_c = 16;                     // 4 leading zeros then 12 data bits
    localparam int i2s_bits_c = 32;                     // Left word then right word

    // --------------------
    // LED bar

    localparam int led_w_c = 4;                         // Default bar width, power of two

    // --------------------
    // Capture FSM

    typedef enum logic [1:0] {
        cap_idle,    // Waiting for the frame strobe
        cap_select,  // CS low, SCK still parked
        cap_shift,   // Clocking the 16 bits
        cap_done     // Raise CS, flag the sample
    } mic_state_t;

endpackage

//--- design/frame_timer.sv
// Dividers must be at least 1; the frame strobe always lands on a BCLK half-period tick
`timescale 1ns/10ps

module frame_timer #(
    parameter int sck_half_div  = 2,
    parameter int bclk_half_div = 2
) (
    input  logic clk,
    input  logic arst_n,
    output logic sck_tick,
    output logic bclk_tick,
    output logic frame_start
);

    localparam int sck_cnt_w  = $clog2(sck_half_div + 1);
    localparam int bclk_cnt_w = $clog2(bclk_half_div + 1);
    localparam int halves_c   = 2 * audio_pkg::i2s_bits_c;  // BCLK half periods per frame
    localparam int half_cnt_w = $clog2(halves_c);

    logic [sck_cnt_w-1:0]  sck_cnt;
    logic [bclk_cnt_w-1:0] bclk_cnt;
    logic [half_cnt_w-1:0] half_cnt;
    logic                  sck_wrap;
    logic                  bclk_wrap;

    assign sck_wrap  = (sck_cnt == sck_cnt_w'(sck_half_div - 1));
    assign bclk_wrap = (bclk_cnt == bclk_cnt_w'(bclk_half_div - 1));

    // --------------------
    // SCK half-period divider

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_cnt  <= '0;
            sck_tick <= 1'b0;
        end else begin
            sck_tick <= sck_wrap;
            sck_cnt  <= sck_wrap ? '0 : sck_cnt + 1'b1;
        end
    end

    // --------------------
    // BCLK divider and frame strobe

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_cnt    <= '0;
            half_cnt    <= '0;
            bclk_tick   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            bclk_tick   <= bclk_wrap;
            bclk_cnt    <= bclk_wrap ? '0 : bclk_cnt + 1'b1;
            // Last half period of the frame closes it
            frame_start <= bclk_wrap && (half_cnt == half_cnt_w'(halves_c - 1));
            if (bclk_wrap) begin
                half_cnt <= half_cnt + 1'b1;    // Wraps at the frame length
            end
        end
    end

endmodule

//--- design/mic_spi_fsm.sv
// One 16-bit read per frame; the whole transfer must end before the next frame strobe
`timescale 1ns/10ps

module mic_spi_fsm #(
    parameter int sck_half_div  = 2,
    parameter int bclk_half_div = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic frame_start,
    input  logic sck_tick,
    output logic mic_cs,
    output logic mic_sck,
    output logic shift_en,
    output logic capture_done
);

    localparam int bit_cnt_w      = $clog2(audio_pkg::mic_bits_c + 1);
    localparam int frame_cycles_c = 2 * bclk_half_div * audio_pkg::i2s_bits_c;
    // Select wait, two SCK edges per bit, then the done cycle
    localparam int xfer_cycles_c  = (2 * audio_pkg::mic_bits_c + 1) * sck_half_div + 2;

    audio_pkg::mic_state_t state;
    logic [bit_cnt_w-1:0]  bit_cnt;        // Rising SCK edges so far

    assign capture_done = (state == audio_pkg::cap_done);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= audio_pkg::cap_idle;
            bit_cnt  <= '0;
            mic_cs   <= 1'b1;
            mic_sck  <= 1'b0;
            shift_en <= 1'b0;
        end else begin
            shift_en <= 1'b0;
            case (state)
                audio_pkg::cap_idle: begin
                    if (frame_start) begin
                        mic_cs  <= 1'b0;
                        bit_cnt <= '0;
                        state   <= audio_pkg::cap_select;
                    end
                end
                audio_pkg::cap_select: begin
                    if (sck_tick) begin
                        state <= audio_pkg::cap_shift;  // CS setup elapsed
                    end
                end
                audio_pkg::cap_shift: begin
                    if (sck_tick) begin
                        if (!mic_sck) begin
                            mic_sck  <= 1'b1;
                            shift_en <= 1'b1;           // Sample on this rising edge
                            bit_cnt  <= bit_cnt + 1'b1;
                        end else begin
                            mic_sck <= 1'b0;
                            if (bit_cnt == bit_cnt_w'(audio_pkg::mic_bits_c)) begin
                                state <= audio_pkg::cap_done;
                            end
                        end
                    end
                end
                audio_pkg::cap_done: begin
                    mic_cs <= 1'b1;
                    state  <= audio_pkg::cap_idle;
                end
                default: state <= audio_pkg::cap_idle;
            endcase
        end
    end

    // --------------------
    // Transfer must fit in one frame

    if (xfer_cycles_c >= frame_cycles_c) begin : g_frame_too_short
        $error("Microphone transfer longer than one I2S frame");
    end

    a_frame_in_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        frame_start |-> (state == audio_pkg::cap_idle)
    );

endmodule

//--- design/mic_sample_path.sv
// Samples arriving with no credit left are dropped; w_led must be a power of two up to 16
`timescale 1ns/10ps

module mic_sample_path #(
    parameter int fifo_depth = 4,
    parameter int w_led      = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              mic_sdo,
    input  logic              shift_en,
    input  logic              capture_done,
    input  logic              pop,
    output logic              push,
    output audio_pkg::audio_t push_data,
    output logic [w_led-1:0]  led
);

    localparam int credit_w    = $clog2(fifo_depth + 1);
    localparam int led_shift_c = 15 - $clog2(w_led);   // Top bits that drive the bar

    logic [audio_pkg::mic_bits_c-1:0] shift_reg;
    audio_pkg::mic_raw_t              raw;
    audio_pkg::mic_raw_t              centered;
    audio_pkg::audio_t                sample;
    logic [credit_w-1:0]              credits;
    logic [audio_pkg::audio_w-1:0]    magnitude;
    logic [audio_pkg::audio_w-1:0]    level;
    logic [w_led-1:0]                 led_next;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_reg <= {shift_reg[audio_pkg::mic_bits_c-2:0], mic_sdo};  // MSB first
        end
    end

    // --------------------
    // Offset removal

    assign raw      = shift_reg[audio_pkg::mic_raw_w-1:0];       // Leading zeros fall off
    assign centered = raw - audio_pkg::mic_offset_c;
    assign sample   = {centered, {audio_pkg::audio_shift_c{1'b0}}};

    always_ff @(posedge clk) begin
        if (capture_done) begin
            push_data <= sample;
        end
    end

    // Push and credit count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push    <= 1'b0;
            credits <= credit_w'(fifo_depth);
        end else begin
            push    <= capture_done && (credits != '0);
            credits <= credits - credit_w'(push) + credit_w'(pop);  // Pop returns a credit
        end
    end

    // --------------------
    // Level meter

    assign magnitude = push_data[audio_pkg::audio_w-1] ? -push_data : push_data;
    assign level     = magnitude >> led_shift_c;

    always_comb begin
        for (int i = 0; i < w_led; i++) begin
            led_next[i] = (level > audio_pkg::audio_w'(i));  // Thermometer, saturates
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (push) begin
            led <= led_next;                                // Dropped samples keep old bar
        end
    end

    a_push_has_credit : assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> (credits != '0)
    );

endmodule

//--- design/sample_fifo.sv
// Depth must be a power of two of at least 2; read data is valid whenever empty is low
`timescale 1ns/10ps

module sample_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  audio_pkg::audio_t push_data,
    input  logic              pop,
    output audio_pkg::audio_t pop_data,
    output logic              empty
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    audio_pkg::audio_t mem [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;      // Words held
    logic              full;

    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(fifo_depth));
    assign pop_data = mem[rd_ptr];  // Head of the queue

    // --------------------
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // --------------------
    // Pointers and occupancy

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Natural wrap
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    // Upstream credits and downstream empty check keep these true
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full
    );

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    );

endmodule

//--- design/i2s_serializer.sv
// Standard I2S, one-bit delay after LRCLK; BCLK stays low until the first frame strobe
`timescale 1ns/10ps

module i2s_serializer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              bclk_tick,
    input  logic              frame_start,
    input  audio_pkg::audio_t pop_data,
    input  logic              empty,
    output logic              pop,
    output logic              i2s_bclk,
    output logic              i2s_lrclk,
    output logic              i2s_sdata
);

    localparam int bit_cnt_w = $clog2(audio_pkg::i2s_bits_c);
    localparam int half_c    = audio_pkg::i2s_bits_c / 2;  // Bits per channel

    logic                            running;
    logic                            fall_edge;
    logic [bit_cnt_w-1:0]            bit_cnt;    // Falling edge number in the frame
    logic [audio_pkg::i2s_bits_c-1:0] frame_sr;
    audio_pkg::audio_t               word;

    assign pop       = frame_start && !empty;
    assign word      = empty ? '0 : pop_data;    // Silence on underrun
    assign fall_edge = bclk_tick && running && i2s_bclk;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            i2s_bclk  <= 1'b0;
            i2s_lrclk <= 1'b0;
            i2s_sdata <= 1'b0;
            bit_cnt   <= '0;
            frame_sr  <= '0;
        end else begin
            if (frame_start) begin
                running <= 1'b1;
            end

            // --------------------
            // BCLK, frame strobe is always a falling edge
            if (bclk_tick && (running || frame_start)) begin
                i2s_bclk <= frame_start ? 1'b0 : !i2s_bclk;
            end

            // --------------------
            // Data and word select
            if (frame_start) begin
                i2s_sdata <= frame_sr[audio_pkg::i2s_bits_c-1];  // Right LSB of last frame
                frame_sr  <= {word, word};                       // Same sample both channels
                i2s_lrclk <= 1'b0;                               // Left
                bit_cnt   <= bit_cnt_w'(1);
            end else if (fall_edge) begin
                i2s_sdata <= frame_sr[audio_pkg::i2s_bits_c-1];
                frame_sr  <= frame_sr << 1;
                i2s_lrclk <= (bit_cnt >= bit_cnt_w'(half_c));    // Right from mid-frame
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end
    end

    // Frame timer must align the strobe with a BCLK half-period tick
    a_frame_on_tick : assert property (
        @(posedge clk) disable iff (!arst_n)
        frame_start |-> bclk_tick
    );

endmodule

//--- design/audio_loopback_top.sv
// Single clk domain; SCK, BCLK and LRCLK are divided outputs, not clocks
`timescale 1ns/10ps

module audio_loopback_top #(
    parameter int sck_half_div  = 2,
    parameter int bclk_half_div = 2,
    parameter int fifo_depth    = 4,
    parameter int w_led         = audio_pkg::led_w_c
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             mic_sdo,
    output logic             mic_cs,
    output logic             mic_sck,
    output logic             i2s_bclk,
    output logic             i2s_lrclk,
    output logic             i2s_sdata,
    output logic [w_led-1:0] led
);

    // --------------------
    // Internal nets

    logic              sck_tick;
    logic              bclk_tick;
    logic              frame_start;
    logic              shift_en;
    logic              capture_done;
    logic              push;
    logic              pop;
    logic              empty;
    audio_pkg::audio_t push_data;
    audio_pkg::audio_t pop_data;

    frame_timer #(
        .sck_half_div  (sck_half_div),
        .bclk_half_div (bclk_half_div)
    ) i_frame_timer (
        .clk         (clk),
        .arst_n      (arst_n),
        .sck_tick    (sck_tick),
        .bclk_tick   (bclk_tick),
        .frame_start (frame_start)
    );

    mic_spi_fsm #(
        .sck_half_div  (sck_half_div),
        .bclk_half_div (bclk_half_div)
    ) i_mic_spi_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .frame_start  (frame_start),
        .sck_tick     (sck_tick),
        .mic_cs       (mic_cs),
        .mic_sck      (mic_sck),
        .shift_en     (shift_en),
        .capture_done (capture_done)
    );

    mic_sample_path #(
        .fifo_depth (fifo_depth),
        .w_led      (w_led)
    ) i_mic_sample_path (
        .clk          (clk),
        .arst_n       (arst_n),
        .mic_sdo      (mic_sdo),
        .shift_en     (shift_en),
        .capture_done (capture_done),
        .pop          (pop),            // Credit return
        .push         (push),
        .push_data    (push_data),
        .led          (led)
    );

    sample_fifo #(
        .fifo_depth (fifo_depth)
    ) i_sample_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    i2s_serializer i_i2s_serializer (
        .clk         (clk),
        .arst_n      (arst_n),
        .bclk_tick   (bclk_tick),
        .frame_start (frame_start),
        .pop_data    (pop_data),
        .empty       (empty),
        .pop         (pop),
        .i2s_bclk    (i2s_bclk),
        .i2s_lrclk   (i2s_lrclk),
        .i2s_sdata   (i2s_sdata)
    );

endmodule

//--- verification/tb_audio_loopback.sv
// Assumes default top parameters and one capture per frame; patterns come from audio_patterns.mem
`timescale 1ns/10ps

module tb_audio_loopback;

    localparam int sck_half_div  = 2;
    localparam int bclk_half_div = 2;
    localparam int fifo_depth    = 4;
    localparam int w_led         = 4;
    localparam int clk_half_ns   = 10;
    localparam int n_patterns    = 16;
    localparam int rng_seed      = 22111;
    localparam int frame_cycles  = 2 * bclk_half_div * 32;
    localparam int watchdog_ns   = (n_patterns + 4) * frame_cycles * 2 * clk_half_ns;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             mic_sdo;
    logic             mic_cs;
    logic             mic_sck;
    logic             i2s_bclk;
    logic             i2s_lrclk;
    logic             i2s_sdata;
    logic [w_led-1:0] led;

    logic [31:0]      patterns [0:n_patterns-1];  // Raw code, audio word, LED code
    logic [15:0]      rx_sr;
    logic [15:0]      left_word;
    logic [15:0]      right_word;
    logic [w_led-1:0] frame_led;                  // Bar at the start of the frame
    logic             bclk_prev;
    logic             lr_prev;
    logic             in_data    = 1'b0;
    int unsigned      pat_idx    = 0;
    int unsigned      frame_count = 0;
    int unsigned      zero_frames = 0;
    int unsigned      check_count = 0;
    int unsigned      fail_count  = 0;

    audio_loopback_top #(
        .sck_half_div  (sck_half_div),
        .bclk_half_div (bclk_half_div),
        .fifo_depth    (fifo_depth),
        .w_led         (w_led)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .mic_sdo   (mic_sdo),
        .mic_cs    (mic_cs),
        .mic_sck   (mic_sck),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_sdata (i2s_sdata),
        .led       (led)
    );

    always #(clk_half_ns) clk = ~clk;

    // --------------------
    // Checking helpers

    task automatic expect_equal(string what, logic [15:0] got, logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[FAIL] %t %s: got %h, expected %h", $time, what, got, exp);
            fail_count++;
        end
    endtask

    function automatic string verdict(int unsigned fails_before);
        return (fail_count == fails_before) ? "ok" : "mismatch";
    endfunction

    task automatic check_frame();
        int unsigned fails_before;
        fails_before = fail_count;
        frame_count++;
        expect_equal("right word vs left word", right_word, left_word);
        if (!in_data && left_word == 16'h0000) begin
            zero_frames++;
            $display("frame %0d: silent before first sample, %s",
                     frame_count, verdict(fails_before));
        end else if (pat_idx < n_patterns) begin
            if (!in_data) begin
                expect_equal("silent frames before data", 16'(zero_frames), 16'd1);
            end
            in_data = 1'b1;
            expect_equal("left word", left_word, patterns[pat_idx][19:4]);
            expect_equal("led bar", 16'(frame_led), 16'(patterns[pat_idx][3:0]));
            $display("frame %0d: sample %0d left %h right %h led %b, %s", frame_count,
                     pat_idx, left_word, right_word, frame_led, verdict(fails_before));
            pat_idx++;
        end
    endtask

    // --------------------
    // Microphone model

    initial begin : mic_model
        logic [15:0] word;
        int          idx;
        int          i;
        mic_sdo = 1'b0;
        idx     = 0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge mic_cs);
            word = {4'b0000, (idx < n_patterns) ? patterns[idx][31:20] : 12'h800};
            idx++;
            #1 mic_sdo = word[15];                  // First bit ready before SCK rises
            for (i = 14; i >= 0; i--) begin
                @(negedge mic_sck);
                #1 mic_sdo = word[i];
            end
        end
    end

    // --------------------
    // I2S decoder, sampled mid-cycle

    always @(negedge clk) begin
        if (!arst_n) begin
            bclk_prev = 1'b0;
            lr_prev   = 1'b0;
            rx_sr     = '0;
        end else begin
            if (i2s_bclk && !bclk_prev) begin
                rx_sr = {rx_sr[14:0], i2s_sdata};
                // LSB of a channel arrives with the LRCLK change
                if (i2s_lrclk != lr_prev) begin
                    if (!lr_prev) begin
                        left_word = rx_sr;
                    end else begin
                        right_word = rx_sr;
                        check_frame();
                        frame_led = led;            // Next capture not pushed yet
                    end
                end
                lr_prev = i2s_lrclk;
            end
            bclk_prev = i2s_bclk;
        end
    end

    // --------------------
    // Main sequence

    initial begin
        int unsigned gap;
        int unsigned fails_before;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(rng_seed));
        arst_n = 1'b0;
        $readmemh("verification/audio_patterns.mem", patterns);
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        gap = 1 + ($urandom % 40);                  // Stays well inside the first frame
        repeat (gap) @(posedge clk);
        @(negedge clk);
        fails_before = fail_count;
        expect_equal("mic_cs after reset", 16'(mic_cs), 16'd1);
        expect_equal("mic_sck after reset", 16'(mic_sck), 16'd0);
        expect_equal("i2s_bclk after reset", 16'(i2s_bclk), 16'd0);
        expect_equal("i2s_lrclk after reset", 16'(i2s_lrclk), 16'd0);
        expect_equal("i2s_sdata after reset", 16'(i2s_sdata), 16'd0);
        $display("reset idle levels: %s", verdict(fails_before));
        wait (pat_idx == n_patterns);
        $display("%0d frames, %0d checks, %0d passed, %0d failed", frame_count,
                 check_count, check_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // --------------------
    // Watchdog

    initial begin
        #(watchdog_ns);
        $display("Timeout: only %0d of %0d samples seen on I2S", pat_idx, n_patterns);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verification/audio_patterns.mem
// Columns: raw mic code (3 hex), expected audio_t (4 hex), expected LED code (1 hex)
// One entry per frame, in capture order
A0020001
80000000
FFF7FF07
0008000F
600E0001
C0040003
400C0003
80100100
7FFFFF00
E0060007
200A0007
9FF1FF00
5FFDFF01
12392307
B5A35A01
00180107

//--- compile.f
design/audio_pkg.sv
design/frame_timer.sv
design/mic_spi_fsm.sv
design/mic_sample_path.sv
design/sample_fifo.sv
design/i2s_serializer.sv
design/audio_loopback_top.sv
verification/tb_audio_loopback.sv

//--- run_sim.sh
#!/bin/sh
# Builds the loopback testbench with Verilator, runs it and searches the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_audio_loopback \
    --Mdir obj_dir -o sim_audio_loopback > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_audio_loopback > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "Simulation passed" sim.log && echo "Run result: PASS" \
    || { echo "Run result: FAIL"; exit 1; }
